// ==== design/usb_pc_pkg.sv ====
// shared definitions for the USB full-speed endpoint protocol controller
// holds the receiver PID classes, the transmit PID codes, the
// transaction state type and the default buffer size width
// imported by every controller module that names one of these types

package usb_pc_pkg;

  // ******************************
  // widths
  // ******************************

  // buffer occupancy and packet size, 64 byte max packet plus one
  localparam int DEFAULT_SIZE_W = 7;

  // ******************************
  // receiver PID classes
  // ******************************

  // classes reported by the receiver for the packet just seen
  // idle doubles as the end of packet marker
  typedef enum logic [2:0] {
    rx_idle = 3'd0,
    rx_data = 3'd1,
    rx_out  = 3'd2,
    rx_in   = 3'd3,
    rx_ack  = 3'd4,
    rx_nak  = 3'd5,
    rx_bad  = 3'd6
  } rx_pid_t;

  // ******************************
  // transmit PID codes
  // ******************************

  typedef enum logic [1:0] {
    tx_idle = 2'd0,
    tx_data = 2'd1,
    tx_ack  = 2'd2,
    tx_nak  = 2'd3
  } tx_pid_t;

  // ******************************
  // transaction states
  // ******************************

  // he = host to endpoint, eh = endpoint to host
  typedef enum logic [3:0] {
    idle           = 4'd0,
    rx_active      = 4'd1,
    he_data        = 4'd2,
    he_good        = 4'd3,
    send_ack       = 4'd4,
    he_done_wait   = 4'd5,
    buf_drain_wait = 4'd6,
    he_bad         = 4'd7,
    ahb_store      = 4'd8,
    tx_active      = 4'd9,
    eh_data        = 4'd10,
    eh_done_wait   = 4'd11,
    eh_done        = 4'd12,
    err_start      = 4'd13,
    send_nak       = 4'd14,
    err_done_wait  = 4'd15
  } pc_state_t;

endpackage

// ==== design/token_decoder.sv ====
// decode stage of the protocol controller
// turns the receiver PID class into one-hot packet events and compares
// the buffer occupancy against empty and against the packet size
// purely combinational and feeds the transaction FSM in the same cycle

`timescale 1ns/1ns

module token_decoder #(
  parameter int size_w = 7
) (
  input  usb_pc_pkg::rx_pid_t rx_packet,
  input  logic [size_w-1:0]   tx_packet_data_size,
  input  logic [size_w-1:0]   buffer_occupancy,
  output logic                tok_out,
  output logic                tok_in,
  output logic                pkt_data,
  output logic                pkt_eop,
  output logic                pkt_bad,
  output logic                buf_empty,
  output logic                buf_ready
);
  import usb_pc_pkg::*;

  // ******************************
  // packet events
  // ******************************

  always_comb begin
    tok_out  = 1'b0;
    tok_in   = 1'b0;
    pkt_data = 1'b0;
    pkt_eop  = 1'b0;
    pkt_bad  = 1'b0;
    case (rx_packet)
      rx_out:  tok_out  = 1'b1;
      rx_in:   tok_in   = 1'b1;
      rx_data: pkt_data = 1'b1;
      rx_bad:  pkt_bad  = 1'b1;
      // host handshakes carry nothing for this endpoint and count as idle
      default: pkt_eop  = 1'b1;
    endcase
  end

  // ******************************
  // buffer level
  // ******************************

  assign buf_empty = (buffer_occupancy == '0);
  assign buf_ready = (buffer_occupancy == tx_packet_data_size);

endmodule

// ==== design/transfer_fsm.sv ====
// execute stage of the protocol controller
// holds the transaction state and works out the next state from the
// decoded packet events, the buffer level, tx_done and buffer_reserved
// next_state is combinational so the result stage registers at the
// same edge as the state itself

`timescale 1ns/1ns

module transfer_fsm (
  input  logic                  tb_clk,
  input  logic                  rst,
  input  logic                  tok_out,
  input  logic                  tok_in,
  input  logic                  pkt_data,
  input  logic                  pkt_eop,
  input  logic                  pkt_bad,
  input  logic                  buf_empty,
  input  logic                  buf_ready,
  input  logic                  tx_done,
  input  logic                  buffer_reserved,
  output usb_pc_pkg::pc_state_t next_state
);
  import usb_pc_pkg::*;

  pc_state_t state_q;

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      state_q <= idle;
    end else begin
      state_q <= next_state;
    end
  end

  // ******************************
  // next state rules
  // ******************************

  always_comb begin
    next_state = state_q;
    case (state_q)
      // bus side reservation wins over any token
      idle: begin
        if (buffer_reserved) begin
          next_state = ahb_store;
        end else if (tok_out) begin
          next_state = rx_active;
        end else if (tok_in) begin
          // nothing reserved to send
          next_state = err_start;
        end
      end

      // host to endpoint
      rx_active: begin
        if (pkt_data) begin
          next_state = he_data;
        end
      end
      he_data: begin
        if (pkt_eop) begin
          next_state = he_good;
        end else if (pkt_bad) begin
          next_state = he_bad;
        end
      end
      he_good:  next_state = send_ack;
      send_ack: next_state = he_done_wait;
      he_done_wait: begin
        if (tx_done) begin
          next_state = buf_drain_wait;
        end
      end
      buf_drain_wait: begin
        if (buf_empty) begin
          next_state = idle;
        end
      end
      he_bad: next_state = err_start;

      // buffer filled by the bus side, then endpoint to host
      ahb_store: begin
        if (tok_in && buf_ready) begin
          next_state = tx_active;
        end else if (tok_out) begin
          // cannot take host data while the buffer is held
          next_state = err_start;
        end
      end
      tx_active: next_state = eh_data;
      eh_data: begin
        if (buf_empty) begin
          next_state = eh_done_wait;
        end
      end
      eh_done_wait: begin
        if (tx_done) begin
          next_state = eh_done;
        end
      end
      eh_done: next_state = idle;

      // NAK answer
      err_start: next_state = send_nak;
      send_nak:  next_state = err_done_wait;
      err_done_wait: begin
        if (tx_done) begin
          next_state = idle;
        end
      end

      default: next_state = state_q;
    endcase
  end

  // state register must always hold a defined enum value out of reset
  a_state_known: assert property (@(posedge tb_clk) disable iff (rst)
    !$isunknown(state_q))
    else $error("transfer_fsm state left the enum");

endmodule

// ==== design/status_encoder.sv ====
// result stage of the protocol controller
// registers the status flags and the transmit PID from the next state,
// so the outputs change at the same edge as the state
// rx_error is sticky from the NAK until a new transfer starts

`timescale 1ns/1ns

module status_encoder (
  input  logic                  tb_clk,
  input  logic                  rst,
  input  usb_pc_pkg::pc_state_t next_state,
  output logic                  rx_data_ready,
  output logic                  rx_transfer_active,
  output logic                  rx_error,
  output logic                  tx_transfer_active,
  output logic                  clear,
  output logic                  d_mode,
  output usb_pc_pkg::tx_pid_t   tx_packet
);
  import usb_pc_pkg::*;

  logic    tx_side;
  logic    rx_error_d;
  tx_pid_t tx_pid_d;

  // ******************************
  // decode of the next state
  // ******************************

  // endpoint owns the bus in these states
  always_comb begin
    case (next_state)
      he_good, send_ack, he_done_wait,
      tx_active, eh_data, eh_done_wait,
      err_start, send_nak, err_done_wait: tx_side = 1'b1;
      default: tx_side = 1'b0;
    endcase
  end

  always_comb begin
    case (next_state)
      send_ack:  tx_pid_d = tx_ack;
      tx_active: tx_pid_d = tx_data;
      send_nak:  tx_pid_d = tx_nak;
      default:   tx_pid_d = tx_idle;
    endcase
  end

  // set by the NAK, cleared when a new transfer opens
  always_comb begin
    rx_error_d = rx_error;
    if (next_state == send_nak) begin
      rx_error_d = 1'b1;
    end else if (next_state == rx_active || next_state == tx_active) begin
      rx_error_d = 1'b0;
    end
  end

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      rx_data_ready      <= 1'b0;
      rx_transfer_active <= 1'b0;
      rx_error           <= 1'b0;
      tx_transfer_active <= 1'b0;
      clear              <= 1'b0;
      d_mode             <= 1'b0;
      tx_packet          <= tx_idle;
    end else begin
      rx_data_ready      <= (next_state == he_good);
      rx_transfer_active <= (next_state == rx_active) || (next_state == he_data);
      rx_error           <= rx_error_d;
      tx_transfer_active <= tx_side;
      clear              <= (next_state == he_bad);
      d_mode             <= tx_side;
      tx_packet          <= tx_pid_d;
    end
  end

  a_pid_in_tx: assert property (@(posedge tb_clk) disable iff (rst)
    (tx_packet != tx_idle) |-> tx_transfer_active)
    else $error("tx_packet sent outside a tx transfer");

  a_one_direction: assert property (@(posedge tb_clk) disable iff (rst)
    !(rx_transfer_active && tx_transfer_active))
    else $error("rx and tx transfer active together");

endmodule

// ==== design/protocol_controller.sv ====
// top level of the USB full-speed endpoint protocol controller
// decode, execute and result stages in a row, one cycle from input
// levels to registered status outputs
// size_w sets the width of the buffer occupancy and packet size

`timescale 1ns/1ns

module protocol_controller #(
  parameter int size_w = usb_pc_pkg::DEFAULT_SIZE_W
) (
  input  logic                tb_clk,
  input  logic                rst,
  input  usb_pc_pkg::rx_pid_t rx_packet,
  input  logic                tx_done,
  input  logic                buffer_reserved,
  input  logic [size_w-1:0]   tx_packet_data_size,
  input  logic [size_w-1:0]   buffer_occupancy,
  output logic                rx_data_ready,
  output logic                rx_transfer_active,
  output logic                rx_error,
  output logic                tx_transfer_active,
  output logic                clear,
  output usb_pc_pkg::tx_pid_t tx_packet,
  output logic                d_mode
);
  import usb_pc_pkg::*;

  // decode to execute
  logic tok_out;
  logic tok_in;
  logic pkt_data;
  logic pkt_eop;
  logic pkt_bad;
  logic buf_empty;
  logic buf_ready;

  // execute to result
  pc_state_t next_state;

  token_decoder #(
    .size_w (size_w)
  ) decode0 (
    .rx_packet           (rx_packet),
    .tx_packet_data_size (tx_packet_data_size),
    .buffer_occupancy    (buffer_occupancy),
    .tok_out             (tok_out),
    .tok_in              (tok_in),
    .pkt_data            (pkt_data),
    .pkt_eop             (pkt_eop),
    .pkt_bad             (pkt_bad),
    .buf_empty           (buf_empty),
    .buf_ready           (buf_ready)
  );

  transfer_fsm fsm0 (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .tok_out         (tok_out),
    .tok_in          (tok_in),
    .pkt_data        (pkt_data),
    .pkt_eop         (pkt_eop),
    .pkt_bad         (pkt_bad),
    .buf_empty       (buf_empty),
    .buf_ready       (buf_ready),
    .tx_done         (tx_done),
    .buffer_reserved (buffer_reserved),
    .next_state      (next_state)
  );

  status_encoder status0 (
    .tb_clk             (tb_clk),
    .rst                (rst),
    .next_state         (next_state),
    .rx_data_ready      (rx_data_ready),
    .rx_transfer_active (rx_transfer_active),
    .rx_error           (rx_error),
    .tx_transfer_active (tx_transfer_active),
    .clear              (clear),
    .d_mode             (d_mode),
    .tx_packet          (tx_packet)
  );

endmodule

// ==== bench/pc_model.svh ====
// reference model of the protocol controller plus the output compare tasks
// included inside the testbench module after the package import
// the model steps once per rising edge from the inputs seen at that edge

`ifndef PC_MODEL_SVH
`define PC_MODEL_SVH

// model state and the outputs it predicts for the next cycle
pc_state_t m_state;
logic      m_rx_data_ready;
logic      m_rx_transfer_active;
logic      m_rx_error;
logic      m_tx_side;
logic      m_clear;
tx_pid_t   m_tx_packet;

task automatic model_reset();
  m_state              = idle;
  m_rx_data_ready      = 1'b0;
  m_rx_transfer_active = 1'b0;
  m_rx_error           = 1'b0;
  m_tx_side            = 1'b0;
  m_clear              = 1'b0;
  m_tx_packet          = tx_idle;
endtask

task automatic model_step(input rx_pid_t rx, input logic done, input logic reserved,
                          input logic [size_w-1:0] size, input logic [size_w-1:0] occ);
  pc_state_t nxt;
  logic      eop;
  // host ack and nak look like idle to this endpoint
  eop = (rx == rx_idle) || (rx == rx_ack) || (rx == rx_nak);
  nxt = m_state;
  case (m_state)
    idle: begin
      if (reserved) nxt = ahb_store;
      else if (rx == rx_out) nxt = rx_active;
      else if (rx == rx_in) nxt = err_start;
    end
    rx_active: if (rx == rx_data) nxt = he_data;
    he_data: begin
      if (eop) nxt = he_good;
      else if (rx == rx_bad) nxt = he_bad;
    end
    he_good:        nxt = send_ack;
    send_ack:       nxt = he_done_wait;
    he_done_wait:   if (done) nxt = buf_drain_wait;
    buf_drain_wait: if (occ == 0) nxt = idle;
    he_bad:         nxt = err_start;
    ahb_store: begin
      if (rx == rx_in && occ == size) nxt = tx_active;
      else if (rx == rx_out) nxt = err_start;
    end
    tx_active:     nxt = eh_data;
    eh_data:       if (occ == 0) nxt = eh_done_wait;
    eh_done_wait:  if (done) nxt = eh_done;
    eh_done:       nxt = idle;
    err_start:     nxt = send_nak;
    send_nak:      nxt = err_done_wait;
    err_done_wait: if (done) nxt = idle;
    default:       nxt = m_state;
  endcase
  m_state = nxt;

  // ******************************
  // registered outputs for the new state
  // ******************************
  m_rx_transfer_active = (nxt == rx_active) || (nxt == he_data);
  m_rx_data_ready      = (nxt == he_good);
  m_clear              = (nxt == he_bad);
  m_tx_side = (nxt == he_good) || (nxt == send_ack) || (nxt == he_done_wait) ||
              (nxt == tx_active) || (nxt == eh_data) || (nxt == eh_done_wait) ||
              (nxt == err_start) || (nxt == send_nak) || (nxt == err_done_wait);
  m_tx_packet = tx_idle;
  if (nxt == send_ack) m_tx_packet = tx_ack;
  if (nxt == tx_active) m_tx_packet = tx_data;
  if (nxt == send_nak) m_tx_packet = tx_nak;
  // sticky until a new transfer opens
  if (nxt == send_nak) m_rx_error = 1'b1;
  else if (nxt == rx_active || nxt == tx_active) m_rx_error = 1'b0;
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
  if (got !== expected) begin
    $display("mismatch at %0t ns: %s is %b, model expects %b", $time, name, got, expected);
    $display("Test FAILED");
    $fatal(1, "run stopped on the first wrong output");
  end
endtask

task automatic check_tx_pid(input tx_pid_t got, input tx_pid_t expected);
  if (got !== expected) begin
    $display("mismatch at %0t ns: tx_packet is %s, model expects %s",
             $time, got.name(), expected.name());
    $display("Test FAILED");
    $fatal(1, "run stopped on the first wrong output");
  end
endtask

`endif

// ==== bench/tb_protocol_controller.sv ====
// testbench for the USB endpoint protocol controller
// drives random receiver PIDs, buffer levels and tx_done from a fixed seed
// and compares every output against a cycle model once per clock

`timescale 1ns/1ns

module tb_protocol_controller;
  import usb_pc_pkg::*;

  localparam int size_w = DEFAULT_SIZE_W;
  localparam int unsigned rng_seed = 32'h898e_42ab;
  localparam int stim_cycles = 5000;
  localparam int cover_limit = 2000;

  logic              tb_clk;
  logic              rst;
  rx_pid_t           rx_packet;
  logic              tx_done;
  logic              buffer_reserved;
  logic [size_w-1:0] tx_packet_data_size;
  logic [size_w-1:0] buffer_occupancy;
  logic              rx_data_ready;
  logic              rx_transfer_active;
  logic              rx_error;
  logic              tx_transfer_active;
  logic              clear;
  tx_pid_t           tx_packet;
  logic              d_mode;

  // response kinds seen so far
  int seen_ack;
  int seen_data;
  int seen_nak;
  int seen_clear;

  `include "pc_model.svh"

  protocol_controller #(
    .size_w (size_w)
  ) dut0 (
    .tb_clk              (tb_clk),
    .rst                 (rst),
    .rx_packet           (rx_packet),
    .tx_done             (tx_done),
    .buffer_reserved     (buffer_reserved),
    .tx_packet_data_size (tx_packet_data_size),
    .buffer_occupancy    (buffer_occupancy),
    .rx_data_ready       (rx_data_ready),
    .rx_transfer_active  (rx_transfer_active),
    .rx_error            (rx_error),
    .tx_transfer_active  (tx_transfer_active),
    .clear               (clear),
    .tx_packet           (tx_packet),
    .d_mode              (d_mode)
  );

  initial begin
    tb_clk = 1'b0;
    forever #5 tb_clk = ~tb_clk;
  end

  // ******************************
  // stimulus and compare
  // ******************************

  task automatic drive_random_inputs();
    int unsigned       pick;
    logic [size_w-1:0] size;
    logic [size_w-1:0] level;
    pick = $urandom_range(0, 99);
    if (pick < 30) rx_packet <= rx_idle;
    else if (pick < 50) rx_packet <= rx_out;
    else if (pick < 70) rx_packet <= rx_in;
    else if (pick < 88) rx_packet <= rx_data;
    else if (pick < 94) rx_packet <= rx_bad;
    else if (pick < 97) rx_packet <= rx_ack;
    else rx_packet <= rx_nak;
    tx_done         <= ($urandom_range(0, 1) == 1);
    buffer_reserved <= ($urandom_range(0, 3) == 0);
    size = $urandom_range(1, (1 << size_w) - 1);
    level = $urandom_range(0, (1 << size_w) - 1);
    tx_packet_data_size <= size;
    // empty and full often enough that the wait states exit
    case ($urandom_range(0, 2))
      0:       buffer_occupancy <= '0;
      1:       buffer_occupancy <= size;
      default: buffer_occupancy <= level;
    endcase
  endtask

  task automatic compare_outputs();
    check_flag("rx_data_ready", rx_data_ready, m_rx_data_ready);
    check_flag("rx_transfer_active", rx_transfer_active, m_rx_transfer_active);
    check_flag("rx_error", rx_error, m_rx_error);
    check_flag("tx_transfer_active", tx_transfer_active, m_tx_side);
    check_flag("d_mode", d_mode, m_tx_side);
    check_flag("clear", clear, m_clear);
    check_tx_pid(tx_packet, m_tx_packet);
  endtask

  // model steps on the inputs held before the edge and outputs are read at negedge
  task automatic run_cycle(input logic rst_next);
    @(posedge tb_clk);
    if (rst) model_reset();
    else model_step(rx_packet, tx_done, buffer_reserved, tx_packet_data_size, buffer_occupancy);
    rst <= rst_next;
    if (!rst_next) drive_random_inputs();
    @(negedge tb_clk);
    compare_outputs();
    if (tx_packet == tx_ack) seen_ack++;
    if (tx_packet == tx_data) seen_data++;
    if (tx_packet == tx_nak) seen_nak++;
    if (clear) seen_clear++;
  endtask

  initial begin
    int   waited;
    logic seen_all;
    rst                 = 1'b1;
    rx_packet           = rx_idle;
    tx_done             = 1'b0;
    buffer_reserved     = 1'b0;
    tx_packet_data_size = '0;
    buffer_occupancy    = '0;
    void'($urandom(rng_seed));
    model_reset();
    for (int i = 0; i < 16; i++) begin
      run_cycle(i != 15);
    end
    // outputs right after reset
    check_flag("rx_data_ready", rx_data_ready, 1'b0);
    check_flag("rx_transfer_active", rx_transfer_active, 1'b0);
    check_flag("rx_error", rx_error, 1'b0);
    check_flag("tx_transfer_active", tx_transfer_active, 1'b0);
    check_flag("d_mode", d_mode, 1'b0);
    check_flag("clear", clear, 1'b0);
    check_tx_pid(tx_packet, tx_idle);
    for (int i = 0; i < stim_cycles; i++) begin
      run_cycle(1'b0);
    end
    // keep going until ack, data, nak and clear have each shown up
    waited = 0;
    seen_all = (seen_ack > 0) && (seen_data > 0) && (seen_nak > 0) && (seen_clear > 0);
    while (!seen_all && waited < cover_limit) begin
      run_cycle(1'b0);
      waited++;
      seen_all = (seen_ack > 0) && (seen_data > 0) && (seen_nak > 0) && (seen_clear > 0);
    end
    if (seen_all) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("timeout: ack, data, nak or clear never appeared within %0d extra cycles",
               cover_limit);
      $display("Test FAILED");
      $fatal(1, "response coverage incomplete");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+bench
design/usb_pc_pkg.sv
design/token_decoder.sv
design/transfer_fsm.sv
design/status_encoder.sv
design/protocol_controller.sv
bench/tb_protocol_controller.sv
